/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := lsu_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_ARGS  := +verilator+error+limit+1000
LOG       := sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard design/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) | tee $(LOG)
	@grep -qx "No errors" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
+incdir+design
design/lsu_pkg.sv
design/lsu_addrcheck.sv
design/lsu_agen.sv
design/lsu_stage_pipe.sv
design/lsu_result_ctl.sv
design/lsu_lsc_ctl.sv
test/lsu_clkgen.sv
test/lsu_asserts.sv
test/lsu_tb.sv

/* design/lsu_addrcheck.sv */
/*
 * Memory map decode of an access into DCCM, PIC or external
 * Misalignment and access fault checks
 */
`default_nettype none
`include "lsu_defines.svh"

module lsu_addrcheck
   import lsu_pkg::*;
(
   input  logic [`LSU_XLEN-1:0] start_addr,
   input  logic [`LSU_XLEN-1:0] end_addr,
   input  lsu_size_e            size,
   output lsu_region_t          region,
   output logic                 access_fault,
   output logic                 misaligned
);

   logic start_in_dccm, start_in_pic;
   logic end_in_dccm, end_in_pic;
   logic unaligned;

   // Windows are power-of-two sized and aligned to their size
   function automatic logic in_window(input logic [`LSU_XLEN-1:0] addr,
                                      input logic [`LSU_XLEN-1:0] base,
                                      input logic [`LSU_XLEN-1:0] wsize);
      return (addr & ~(wsize - 1'b1)) == base;
   endfunction

   assign start_in_dccm = in_window(start_addr, `LSU_DCCM_BASE, `LSU_DCCM_SIZE);
   assign start_in_pic  = in_window(start_addr, `LSU_PIC_BASE, `LSU_PIC_SIZE);
   assign end_in_dccm   = in_window(end_addr, `LSU_DCCM_BASE, `LSU_DCCM_SIZE);
   assign end_in_pic    = in_window(end_addr, `LSU_PIC_BASE, `LSU_PIC_SIZE);

   assign region.in_dccm  = start_in_dccm;
   assign region.in_pic   = start_in_pic;
   assign region.external = ~start_in_dccm & ~start_in_pic;

   always_comb begin
      case (size)
         LSU_HALF: unaligned = start_addr[0];
         LSU_WORD: unaligned = |start_addr[1:0];
         default:  unaligned = 1'b0;
      endcase
   end

   // DCCM handles unaligned accesses itself
   assign misaligned = unaligned & ~start_in_dccm;

   // Access straddles two regions, or PIC touched with less than a word
   assign access_fault = (start_in_dccm != end_in_dccm) |
                         (start_in_pic != end_in_pic) |
                         (start_in_pic & (size != LSU_WORD));

endmodule

`default_nettype wire

/* design/lsu_agen.sv */
/*
 * Decode to dc1 capture and start/end address generation
 */
`default_nettype none
`include "lsu_defines.svh"

module lsu_agen
   import lsu_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst,
   input  lsu_pkt_t                 lsu_p,
   input  logic [`LSU_XLEN-1:0]     rs1_d,
   input  logic [`LSU_XLEN-1:0]     rs2_d,
   input  logic [`LSU_OFFSET_W-1:0] offset_d,
   input  logic                     flush_dc2_up,
   output lsu_stage_t               stage_dc1
);

   lsu_pkt_t                 pkt_dc1;
   logic [`LSU_XLEN-1:0]     rs1_dc1;
   logic [`LSU_OFFSET_W-1:0] offset_dc1;
   logic [`LSU_XLEN-1:0]     store_data_dc1;
   logic [`LSU_XLEN-1:0]     start_addr_dc1;
   logic [`LSU_XLEN-1:0]     end_addr_dc1;
   logic [1:0]               size_m1_dc1;
   lsu_region_t              region_dc1;
   logic                     access_fault_dc1;
   logic                     misaligned_dc1;

   //**************************************************
   // Decode capture
   //**************************************************
   always_ff @(posedge clk) begin
      if (lsu_p.valid) begin
         pkt_dc1        <= lsu_p;
         rs1_dc1        <= rs1_d;
         offset_dc1     <= offset_d;
         store_data_dc1 <= rs2_d;
      end
      // Valid bit overrides the payload capture
      if (rst) begin
         pkt_dc1.valid <= 1'b0;
      end else begin
         pkt_dc1.valid <= lsu_p.valid & ~flush_dc2_up;
      end
   end

   //**************************************************
   // Address generation
   //**************************************************
   assign start_addr_dc1 = rs1_dc1 +
      {{(`LSU_XLEN-`LSU_OFFSET_W){offset_dc1[`LSU_OFFSET_W-1]}}, offset_dc1};

   always_comb begin
      case (pkt_dc1.size)
         LSU_HALF: size_m1_dc1 = 2'd1;
         LSU_WORD: size_m1_dc1 = 2'd3;
         default:  size_m1_dc1 = 2'd0;
      endcase
   end

   // Last byte touched by the access
   assign end_addr_dc1 = start_addr_dc1 + {{(`LSU_XLEN-2){1'b0}}, size_m1_dc1};

   lsu_addrcheck addrcheck (
      .start_addr   (start_addr_dc1),
      .end_addr     (end_addr_dc1),
      .size         (pkt_dc1.size),
      .region       (region_dc1),
      .access_fault (access_fault_dc1),
      .misaligned   (misaligned_dc1)
   );

   always_comb begin
      stage_dc1.pkt          = pkt_dc1;
      stage_dc1.addr         = start_addr_dc1;
      stage_dc1.end_addr     = end_addr_dc1;
      stage_dc1.region       = region_dc1;
      stage_dc1.access_fault = access_fault_dc1;
      stage_dc1.misaligned   = misaligned_dc1;
      stage_dc1.store_data   = store_data_dc1;
   end

endmodule

`default_nettype wire

/* design/lsu_defines.svh */
/*
 * LSU data and offset widths
 * Memory map of the DCCM and PIC windows
 */
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Datapath widths
`define LSU_XLEN      32
`define LSU_OFFSET_W  12

// DCCM window, 64 KB
`define LSU_DCCM_BASE 32'hF004_0000
`define LSU_DCCM_SIZE 32'h0001_0000

// PIC window, 32 KB
`define LSU_PIC_BASE  32'hF00C_0000
`define LSU_PIC_SIZE  32'h0000_8000

`endif

/* design/lsu_lsc_ctl.sv */
/*
 * LSU control top: dc1 address generation, dc2-dc5 stages,
 * result and exception control
 */
`default_nettype none
`include "lsu_defines.svh"

module lsu_lsc_ctl
   import lsu_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst,
   input  lsu_pkt_t                 lsu_p,
   input  logic [`LSU_XLEN-1:0]     rs1_d,
   input  logic [`LSU_XLEN-1:0]     rs2_d,
   input  logic [`LSU_OFFSET_W-1:0] offset_d,
   input  logic                     flush_dc2_up,
   input  logic                     flush_dc3,
   input  logic                     flush_dc4,
   input  logic                     flush_dc5,
   input  logic [`LSU_XLEN-1:0]     ld_data_dc3,
   input  logic [`LSU_XLEN-1:0]     bus_read_data_dc3,
   input  logic                     ld_bus_error_dc3,
   output logic                     lsu_exc_dc2,
   output lsu_error_pkt_t           lsu_error_pkt_dc3,
   output logic [`LSU_XLEN-1:0]     lsu_result_dc3,
   output logic [`LSU_XLEN-1:0]     lsu_result_dc4,
   output logic [`LSU_XLEN-1:0]     lsu_addr_dc3,
   output lsu_region_t              region_dc3,
   output logic [`LSU_XLEN-1:0]     lsu_addr_dc5,
   output logic [`LSU_XLEN-1:0]     store_data_dc5,
   output logic                     lsu_commit_dc5
);

   lsu_stage_t stage_dc1, stage_dc2, stage_dc3, stage_dc4, stage_dc5;

   lsu_agen agen (
      .clk, .rst, .lsu_p, .rs1_d, .rs2_d, .offset_d, .flush_dc2_up,
      .stage_dc1 (stage_dc1)
   );

   lsu_stage_pipe pipe (
      .clk, .rst, .stage_dc1, .flush_dc2_up, .flush_dc3, .flush_dc4,
      .stage_dc2 (stage_dc2),
      .stage_dc3 (stage_dc3),
      .stage_dc4 (stage_dc4),
      .stage_dc5 (stage_dc5)
   );

   lsu_result_ctl result_ctl (
      .clk, .rst, .stage_dc2, .stage_dc3, .stage_dc5,
      .ld_data_dc3, .bus_read_data_dc3, .ld_bus_error_dc3,
      .flush_dc3, .flush_dc5,
      .lsu_exc_dc2, .lsu_error_pkt_dc3, .lsu_result_dc3, .lsu_result_dc4,
      .lsu_commit_dc5
   );

   // Address and data down the pipe
   assign lsu_addr_dc3   = stage_dc3.addr;
   assign region_dc3     = stage_dc3.region;
   assign lsu_addr_dc5   = stage_dc5.addr;
   assign store_data_dc5 = stage_dc5.store_data;

endmodule

`default_nettype wire

/* design/lsu_pkg.sv */
/*
 * LSU types: operation, size and exception enums
 * Control packet, region, pipe stage and error packet structs
 */
`default_nettype none
`include "lsu_defines.svh"

package lsu_pkg;

   typedef enum logic {
      LSU_LOAD  = 1'b0,
      LSU_STORE = 1'b1
   } lsu_op_e;

   typedef enum logic [1:0] {
      LSU_BYTE = 2'b00,
      LSU_HALF = 2'b01,
      LSU_WORD = 2'b10
   } lsu_size_e;

   // Misalign is encoded as zero on the error interface
   typedef enum logic {
      LSU_EXC_MISALIGN = 1'b0,
      LSU_EXC_ACCESS   = 1'b1
   } lsu_exc_e;

   typedef struct packed {
      logic      valid;
      lsu_op_e   op;
      lsu_size_e size;
      logic      unsign;
   } lsu_pkt_t;

   typedef struct packed {
      logic in_dccm;
      logic in_pic;
      logic external;
   } lsu_region_t;

   // Everything one pipe stage carries
   typedef struct packed {
      lsu_pkt_t                 pkt;
      logic [`LSU_XLEN-1:0]     addr;
      logic [`LSU_XLEN-1:0]     end_addr;
      lsu_region_t              region;
      logic                     access_fault;
      logic                     misaligned;
      logic [`LSU_XLEN-1:0]     store_data;
   } lsu_stage_t;

   typedef struct packed {
      logic                 exc_valid;
      lsu_op_e              inst_type;
      lsu_exc_e             exc_type;
      logic [`LSU_XLEN-1:0] addr;
   } lsu_error_pkt_t;

endpackage

`default_nettype wire

/* design/lsu_result_ctl.sv */
/*
 * Load data select and format, dc4 result register
 * Exception and error packet generation, commit
 */
`default_nettype none
`include "lsu_defines.svh"

module lsu_result_ctl
   import lsu_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst,
   input  lsu_stage_t           stage_dc2,
   input  lsu_stage_t           stage_dc3,
   input  lsu_stage_t           stage_dc5,
   input  logic [`LSU_XLEN-1:0] ld_data_dc3,
   input  logic [`LSU_XLEN-1:0] bus_read_data_dc3,
   input  logic                 ld_bus_error_dc3,
   input  logic                 flush_dc3,
   input  logic                 flush_dc5,
   output logic                 lsu_exc_dc2,
   output lsu_error_pkt_t       lsu_error_pkt_dc3,
   output logic [`LSU_XLEN-1:0] lsu_result_dc3,
   output logic [`LSU_XLEN-1:0] lsu_result_dc4,
   output logic                 lsu_commit_dc5
);

   logic [`LSU_XLEN-1:0] ld_datafn_dc3;
   logic                 sx;

   //**************************************************
   // Load data formatting
   //**************************************************
   assign ld_datafn_dc3 = stage_dc3.region.external ? bus_read_data_dc3 : ld_data_dc3;

   always_comb begin
      sx = ~stage_dc3.pkt.unsign;
      case (stage_dc3.pkt.size)
         LSU_BYTE:
            lsu_result_dc3 = {{(`LSU_XLEN-8){sx & ld_datafn_dc3[7]}}, ld_datafn_dc3[7:0]};
         LSU_HALF:
            lsu_result_dc3 = {{(`LSU_XLEN-16){sx & ld_datafn_dc3[15]}}, ld_datafn_dc3[15:0]};
         default:
            lsu_result_dc3 = ld_datafn_dc3;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         lsu_result_dc4 <= '0;
      end else begin
         lsu_result_dc4 <= lsu_result_dc3;
      end
   end

   //**************************************************
   // Exceptions and commit
   //**************************************************
   // Early warning to decode, one stage ahead of the packet
   assign lsu_exc_dc2 = stage_dc2.pkt.valid & (stage_dc2.access_fault | stage_dc2.misaligned);

   assign lsu_error_pkt_dc3.exc_valid = stage_dc3.pkt.valid & ~flush_dc3 &
      (stage_dc3.access_fault | stage_dc3.misaligned | ld_bus_error_dc3);
   assign lsu_error_pkt_dc3.inst_type = stage_dc3.pkt.op;
   assign lsu_error_pkt_dc3.exc_type  = stage_dc3.misaligned ? LSU_EXC_MISALIGN : LSU_EXC_ACCESS;
   assign lsu_error_pkt_dc3.addr      = stage_dc3.addr;

   // A dc5 flush still allows the writeback to be dropped here
   assign lsu_commit_dc5 = stage_dc5.pkt.valid & ~flush_dc5;

endmodule

`default_nettype wire

/* design/lsu_stage_pipe.sv */
/*
 * Stage registers dc2 to dc5
 * Flush kills the valid bit on each transfer
 */
`default_nettype none

module lsu_stage_pipe
   import lsu_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  lsu_stage_t stage_dc1,
   input  logic       flush_dc2_up,
   input  logic       flush_dc3,
   input  logic       flush_dc4,
   output lsu_stage_t stage_dc2,
   output lsu_stage_t stage_dc3,
   output lsu_stage_t stage_dc4,
   output lsu_stage_t stage_dc5
);

   lsu_stage_t stage_q  [2:5];
   lsu_stage_t stage_in [2:5];
   logic [5:2] kill;

   // Kill bit for the transfer into each stage
   //   dc1->dc2 and dc2->dc3 by flush_dc2_up
   //   dc3->dc4 by flush_dc3, dc4->dc5 by flush_dc4
   assign kill = {flush_dc4, flush_dc3, flush_dc2_up, flush_dc2_up};

   //**************************************************
   // Next stage contents
   //**************************************************
   always_comb begin
      stage_in[2] = stage_dc1;
      for (int i = 3; i <= 5; i++) begin
         stage_in[i] = stage_q[i-1];
      end
      for (int i = 2; i <= 5; i++) begin
         stage_in[i].pkt.valid = stage_in[i].pkt.valid & ~kill[i];
      end
   end

   //**************************************************
   // Stage registers
   //**************************************************
   always_ff @(posedge clk) begin
      for (int i = 2; i <= 5; i++) begin
         stage_q[i] <= stage_in[i];
         // Only the valid bit is control state
         if (rst) begin
            stage_q[i].pkt.valid <= 1'b0;
         end
      end
   end

   assign stage_dc2 = stage_q[2];
   assign stage_dc3 = stage_q[3];
   assign stage_dc4 = stage_q[4];
   assign stage_dc5 = stage_q[5];

endmodule

`default_nettype wire

/* test/lsu_asserts.sv */
/*
 * Concurrent checks on the LSU control top: reset quiet,
 * commit timing and data, flush kill, exception and bus error rules
 */
`default_nettype none
`include "lsu_defines.svh"

module lsu_asserts
   import lsu_pkg::*;
(
   input logic                 clk,
   input logic                 rst,
   input lsu_pkt_t             lsu_p,
   input logic [`LSU_XLEN-1:0] rs2_d,
   input logic                 flush_dc2_up,
   input logic                 flush_dc3,
   input logic                 flush_dc4,
   input logic                 flush_dc5,
   input logic                 ld_bus_error_dc3,
   input logic                 lsu_exc_dc2,
   input lsu_error_pkt_t       lsu_error_pkt_dc3,
   input logic [`LSU_XLEN-1:0] lsu_addr_dc3,
   input logic [`LSU_XLEN-1:0] lsu_addr_dc5,
   input logic [`LSU_XLEN-1:0] store_data_dc5,
   input logic                 lsu_commit_dc5
);
   timeunit 1ns;
   timeprecision 100ps;

   int fail_count = 0;

   task automatic count_failure(input string what);
      fail_count++;
      $error("%s", what);
   endtask

   // Quiet while in reset and in the first cycle after release
   reset_quiet: assert property (@(posedge clk)
      (rst && $past(rst)) || $fell(rst) |->
         !lsu_commit_dc5 && !lsu_exc_dc2 && !lsu_error_pkt_dc3.exc_valid)
      else count_failure("commit or exception active during reset");

   // Commit five cycles after issue unless a flush hit it on the way
   commit_timing: assert property (@(posedge clk) disable iff (rst)
      lsu_commit_dc5 == ($past(lsu_p.valid, 5) && !$past(flush_dc2_up, 5) &&
                         !$past(flush_dc2_up, 4) && !$past(flush_dc2_up, 3) &&
                         !$past(flush_dc3, 2) && !$past(flush_dc4, 1) && !flush_dc5))
      else count_failure("commit does not follow issue and flush history");

   commit_data: assert property (@(posedge clk) disable iff (rst)
      lsu_commit_dc5 |->
         store_data_dc5 == $past(rs2_d, 5) && lsu_addr_dc5 == $past(lsu_addr_dc3, 2))
      else count_failure("committed address or store data differs from issue");

   flush_no_exc: assert property (@(posedge clk) disable iff (rst)
      flush_dc3 || $past(flush_dc2_up, 1) || $past(flush_dc2_up, 2) ||
      $past(flush_dc2_up, 3) |-> !lsu_error_pkt_dc3.exc_valid)
      else count_failure("exception raised by a flushed operation");

   // Early dc2 warning turns into a dc3 exception
   exc_dc2_to_dc3: assert property (@(posedge clk) disable iff (rst)
      !$past(flush_dc2_up) && !flush_dc3 && !ld_bus_error_dc3 |->
         lsu_error_pkt_dc3.exc_valid == $past(lsu_exc_dc2))
      else count_failure("dc2 exception and dc3 exception disagree");

   bus_error_load: assert property (@(posedge clk) disable iff (rst)
      ld_bus_error_dc3 && $past(lsu_p.valid, 3) && $past(lsu_p.op, 3) == LSU_LOAD &&
      !$past(flush_dc2_up, 3) && !$past(flush_dc2_up, 2) && !$past(flush_dc2_up, 1) &&
      !flush_dc3 |->
         lsu_error_pkt_dc3.exc_valid && lsu_error_pkt_dc3.inst_type == LSU_LOAD)
      else count_failure("load bus error did not raise a load exception");

endmodule

bind lsu_lsc_ctl lsu_asserts asserts0 (.*);

`default_nettype wire

/* test/lsu_clkgen.sv */
/*
 * Free-running testbench clock, 40 ns period
 */
`default_nettype none

module lsu_clkgen (
   output logic clk
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam real HALF_PERIOD = 20.0;

   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;
   end

endmodule

`default_nettype wire

/* test/lsu_tb.sv */
/*
 * LSU control testbench: directed and random load/store traffic,
 * reference model of address, faults and load format, watchdog
 */
`default_nettype none
`include "lsu_defines.svh"

module lsu_tb
   import lsu_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int PERIOD_NS    = 40;
   localparam int RESET_CYCLES = 10;
   localparam int DRIVE_DELAY  = 2;

   // Everything driven in one cycle: the issued operation, its later
   // load data, and the flushes of that cycle {dc5, dc4, dc3, dc2_up}
   typedef struct packed {
      lsu_pkt_t                 pkt;
      logic [`LSU_XLEN-1:0]     base;
      logic [`LSU_OFFSET_W-1:0] offset;
      logic [`LSU_XLEN-1:0]     store_data;
      logic [`LSU_XLEN-1:0]     dccm_data;
      logic [`LSU_XLEN-1:0]     bus_data;
      logic                     bus_error;
      logic [3:0]               flush;
   } cycle_rec_t;

   logic                     clk, rst;
   lsu_pkt_t                 lsu_p;
   logic [`LSU_XLEN-1:0]     rs1_d, rs2_d, ld_data_dc3, bus_read_data_dc3;
   logic [`LSU_OFFSET_W-1:0] offset_d;
   logic                     flush_dc2_up, flush_dc3, flush_dc4, flush_dc5;
   logic                     ld_bus_error_dc3, lsu_exc_dc2, lsu_commit_dc5;
   lsu_error_pkt_t           lsu_error_pkt_dc3;
   logic [`LSU_XLEN-1:0]     lsu_result_dc3, lsu_result_dc4, lsu_addr_dc3;
   logic [`LSU_XLEN-1:0]     lsu_addr_dc5, store_data_dc5;
   lsu_region_t              region_dc3;

   cycle_rec_t           recs[$];
   int                   seed = 16825;
   int                   errors = 0;
   int                   checks = 0;
   int                   ops_issued = 0;
   int                   cyc = -1;
   logic                 running = 1'b0;
   logic                 prev_live = 1'b0;
   logic [`LSU_XLEN-1:0] prev_result;
   longint               watchdog_ns = 0;

   lsu_clkgen clkgen (.clk(clk));

   lsu_lsc_ctl dut0 (.*);

   //**************************************************
   // Reference model
   //**************************************************
   function automatic logic in_dccm(input logic [`LSU_XLEN-1:0] a);
      return (a >= `LSU_DCCM_BASE) && (a < (`LSU_DCCM_BASE + `LSU_DCCM_SIZE));
   endfunction

   function automatic logic in_pic(input logic [`LSU_XLEN-1:0] a);
      return (a >= `LSU_PIC_BASE) && (a < (`LSU_PIC_BASE + `LSU_PIC_SIZE));
   endfunction

   function automatic logic [`LSU_XLEN-1:0] access_bytes(input lsu_size_e s);
      case (s)
         LSU_HALF: return 32'd2;
         LSU_WORD: return 32'd4;
         default:  return 32'd1;
      endcase
   endfunction

   function automatic logic [`LSU_XLEN-1:0] format_load(input cycle_rec_t r, input logic ext);
      logic [`LSU_XLEN-1:0] data;
      data = ext ? r.bus_data : r.dccm_data;
      case (r.pkt.size)
         LSU_BYTE: return r.pkt.unsign ? {24'h0, data[7:0]} : {{24{data[7]}}, data[7:0]};
         LSU_HALF: return r.pkt.unsign ? {16'h0, data[15:0]} : {{16{data[15]}}, data[15:0]};
         default:  return data;
      endcase
   endfunction

   task automatic check_value(input string name, input logic [`LSU_XLEN-1:0] expected,
                              input logic [`LSU_XLEN-1:0] actual);
      checks++;
      assert (actual === expected) else begin
         $display("FAILED %0t ns %s expected %h actual %h", $time, name, expected, actual);
         errors++;
      end
   endtask

   // Called mid-cycle, checks the operation issued three cycles earlier
   task automatic check_cycle(input int c);
      cycle_rec_t           r;
      logic [`LSU_XLEN-1:0] addr, end_addr, result;
      logic                 live, mis, fault, exc;
      lsu_exc_e             kind;
      lsu_region_t          region;
      if (c < 3) begin
         return;
      end
      r = recs[c-3];
      live = r.pkt.valid && !r.flush[0] && !recs[c-2].flush[0] && !recs[c-1].flush[0];
      addr = r.base + {{(`LSU_XLEN-`LSU_OFFSET_W){r.offset[`LSU_OFFSET_W-1]}}, r.offset};
      end_addr = addr + access_bytes(r.pkt.size) - 32'd1;
      region.in_dccm = in_dccm(addr);
      region.in_pic = in_pic(addr);
      region.external = !region.in_dccm && !region.in_pic;
      mis = !in_dccm(addr) && ((r.pkt.size == LSU_HALF && addr[0]) ||
                               (r.pkt.size == LSU_WORD && addr[1:0] != 2'b00));
      fault = (in_dccm(addr) != in_dccm(end_addr)) || (in_pic(addr) != in_pic(end_addr)) ||
              (in_pic(addr) && r.pkt.size != LSU_WORD);
      exc = live && !recs[c].flush[1] && (mis || fault || r.bus_error);
      kind = mis ? LSU_EXC_MISALIGN : LSU_EXC_ACCESS;
      result = format_load(r, region.external);
      check_value("lsu_error_pkt_dc3.exc_valid", exc, lsu_error_pkt_dc3.exc_valid);
      if (live) begin
         check_value("lsu_addr_dc3", addr, lsu_addr_dc3);
         check_value("region_dc3", region, region_dc3);
         check_value("lsu_result_dc3", result, lsu_result_dc3);
      end
      if (exc) begin
         check_value("lsu_error_pkt_dc3.exc_type", kind, lsu_error_pkt_dc3.exc_type);
         check_value("lsu_error_pkt_dc3.inst_type", r.pkt.op, lsu_error_pkt_dc3.inst_type);
         check_value("lsu_error_pkt_dc3.addr", addr, lsu_error_pkt_dc3.addr);
      end
      if (prev_live) begin
         check_value("lsu_result_dc4", prev_result, lsu_result_dc4);
      end
      prev_live = live;
      prev_result = result;
   endtask

   //**************************************************
   // Stimulus
   //**************************************************
   task automatic add_op(input lsu_op_e op, input lsu_size_e size, input logic unsign,
                         input logic [`LSU_XLEN-1:0] base,
                         input logic [`LSU_OFFSET_W-1:0] offset, input logic bus_error);
      cycle_rec_t r;
      r = '0;
      r.pkt.valid = 1'b1;
      r.pkt.op = op;
      r.pkt.size = size;
      r.pkt.unsign = unsign;
      r.base = base;
      r.offset = offset;
      r.store_data = $random(seed);
      r.dccm_data = $random(seed);
      r.bus_data = $random(seed);
      r.bus_error = bus_error;
      recs.push_back(r);
      ops_issued++;
   endtask

   task automatic add_idle(input int n);
      cycle_rec_t r;
      r = '0;
      repeat (n) recs.push_back(r);
   endtask

   task automatic add_random_op();
      logic [`LSU_XLEN-1:0] rnd, off, base;
      lsu_size_e            size;
      rnd = $random(seed);
      off = $random(seed);
      case (rnd[1:0])
         2'd0:    base = `LSU_DCCM_BASE | {16'h0, rnd[31:16]};
         2'd1:    base = `LSU_PIC_BASE | {17'h0, rnd[30:16]};
         default: base = $random(seed);
      endcase
      size = (rnd[3:2] == 2'd3) ? LSU_WORD : lsu_size_e'(rnd[3:2]);
      add_op(lsu_op_e'(rnd[4]), size, rnd[5], base, off[`LSU_OFFSET_W-1:0], rnd[6] & rnd[7]);
   endtask

   // Stage 1 is decode, 2 and 3 are dc1 and dc2, then dc3, dc4, dc5
   task automatic flush_at(input int i, input int stage);
      cycle_rec_t r;
      int         k;
      k = i + stage - 1;
      r = recs[k];
      case (stage)
         1, 2, 3: r.flush[0] = 1'b1;
         4:       r.flush[1] = 1'b1;
         5:       r.flush[2] = 1'b1;
         default: r.flush[3] = 1'b1;
      endcase
      recs[k] = r;
   endtask

   task automatic drive_cycle(input int c);
      cycle_rec_t r;
      cycle_rec_t d;
      r = recs[c];
      d = '0;
      if (c >= 3) begin
         d = recs[c-3];
      end
      cyc = c;
      lsu_p = r.pkt;
      rs1_d = r.base;
      rs2_d = r.store_data;
      offset_d = r.offset;
      {flush_dc5, flush_dc4, flush_dc3, flush_dc2_up} = r.flush;
      ld_data_dc3 = d.dccm_data;
      bus_read_data_dc3 = d.bus_data;
      ld_bus_error_dc3 = d.bus_error;
   endtask

   always @(negedge clk) begin
      if (running) begin
         check_cycle(cyc);
      end
   end

   initial begin
      int idx;
      int total;
      rst = 1'b1;
      // Misaligned store traffic in the first half of reset
      lsu_p = '{valid: 1'b1, op: LSU_STORE, size: LSU_WORD, unsign: 1'b0};
      rs1_d = 32'h1000_0002;
      rs2_d = '0;
      offset_d = '0;
      flush_dc2_up = 1'b0;
      flush_dc3 = 1'b0;
      flush_dc4 = 1'b0;
      flush_dc5 = 1'b0;
      ld_data_dc3 = '0;
      bus_read_data_dc3 = '0;
      ld_bus_error_dc3 = 1'b0;

      // Faults: unaligned external word, PIC half, word leaving DCCM
      add_op(LSU_LOAD, LSU_WORD, 1'b0, 32'h2000_0001, 12'h000, 1'b0);
      add_op(LSU_LOAD, LSU_HALF, 1'b0, `LSU_PIC_BASE, 12'h004, 1'b0);
      add_op(LSU_STORE, LSU_WORD, 1'b0, `LSU_DCCM_BASE + `LSU_DCCM_SIZE - 2, 12'h000, 1'b0);
      add_op(LSU_LOAD, LSU_WORD, 1'b0, `LSU_DCCM_BASE, 12'h010, 1'b0);
      add_op(LSU_LOAD, LSU_WORD, 1'b0, 32'h4000_0000, 12'hFFC, 1'b1);
      add_idle(2);
      // Misaligned stores flushed at each stage in turn
      for (int s = 1; s <= 6; s++) begin
         idx = recs.size();
         add_op(LSU_STORE, LSU_WORD, 1'b0, 32'h1000_0002, 12'h000, 1'b0);
         add_idle(6);
         flush_at(idx, s);
      end
      for (int i = 0; i < 48; i++) begin
         add_random_op();
      end
      add_idle(8);
      watchdog_ns = longint'(ops_issued) * 10 * PERIOD_NS + RESET_CYCLES * PERIOD_NS;

      repeat (RESET_CYCLES / 2) @(posedge clk);
      #DRIVE_DELAY;
      lsu_p = '0;
      rs1_d = '0;
      repeat (RESET_CYCLES - RESET_CYCLES / 2) @(posedge clk);
      #DRIVE_DELAY;
      rst = 1'b0;
      running = 1'b1;
      foreach (recs[c]) begin
         @(posedge clk);
         #DRIVE_DELAY;
         drive_cycle(c);
      end
      @(posedge clk);
      #DRIVE_DELAY;
      running = 1'b0;

      total = errors + dut0.asserts0.fail_count;
      $display("Checks %0d, check errors %0d, assertion errors %0d",
               checks, errors, dut0.asserts0.fail_count);
      if (total == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   // Watchdog
   initial begin
      wait (watchdog_ns != 0);
      #(watchdog_ns);
      $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
      $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire
